//--- files.f
source/noc_router_pkg.sv
source/route_compute.sv
source/port_arbiter.sv
source/switch_traversal.sv
source/noc_router.sv
verification/noc_router_tb.sv

//--- source/noc_router.sv
//*********************************************************************
// Switch core of one mesh router at (X_POS, Y_POS). Five input route
// stages, one round-robin arbiter per output and the crossbar stage.
// All port vectors are flat and indexed by port code N, S, W, E, L.
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  wire                                                         clk,
  input  wire                                                         rst_i,
  input  wire  [noc_router_pkg::NUM_PORTS-1:0]                        in_valid_i,
  input  wire  [noc_router_pkg::NUM_PORTS*noc_router_pkg::FLIT_W-1:0] in_flit_i,
  input  wire  [noc_router_pkg::NUM_PORTS-1:0]                        out_credit_i,
  output logic [noc_router_pkg::NUM_PORTS-1:0]                        in_credit_o,
  output logic [noc_router_pkg::NUM_PORTS-1:0]                        out_valid_o,
  output logic [noc_router_pkg::NUM_PORTS*noc_router_pkg::FLIT_W-1:0] out_flit_o
);

  logic [noc_router_pkg::NUM_PORTS-1:0]                           req_valid;
  logic [noc_router_pkg::NUM_PORTS*noc_router_pkg::PORT_W-1:0]    req_port;
  logic [noc_router_pkg::NUM_PORTS*noc_router_pkg::FLIT_W-1:0]    held_flit;
  logic [noc_router_pkg::NUM_PORTS*noc_router_pkg::NUM_PORTS-1:0] arb_grant;
  logic [noc_router_pkg::NUM_PORTS-1:0]                           in_grant;

  for (genvar gi = 0; gi < noc_router_pkg::NUM_PORTS; gi++) begin : g_in
    route_compute #(
      .X_POS (X_POS),
      .Y_POS (Y_POS)
    ) u_route (
      .clk          (clk),
      .rst_i        (rst_i),
      .flit_valid_i (in_valid_i[gi]),
      .flit_i       (in_flit_i[gi*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W]),
      .grant_i      (in_grant[gi]),
      .req_valid_o  (req_valid[gi]),
      .req_port_o   (req_port[gi*noc_router_pkg::PORT_W +: noc_router_pkg::PORT_W]),
      .flit_o       (held_flit[gi*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W])
    );
  end

  // one arbiter per output, grant slice at its port code
  port_arbiter #(.OUT_PORT(noc_router_pkg::PORT_N)) u_arb_n (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_port_i  (req_port),
    .credit_i    (out_credit_i[noc_router_pkg::PORT_N]),
    .grant_o     (arb_grant[noc_router_pkg::PORT_N*noc_router_pkg::NUM_PORTS
                            +: noc_router_pkg::NUM_PORTS])
  );

  port_arbiter #(.OUT_PORT(noc_router_pkg::PORT_S)) u_arb_s (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_port_i  (req_port),
    .credit_i    (out_credit_i[noc_router_pkg::PORT_S]),
    .grant_o     (arb_grant[noc_router_pkg::PORT_S*noc_router_pkg::NUM_PORTS
                            +: noc_router_pkg::NUM_PORTS])
  );

  port_arbiter #(.OUT_PORT(noc_router_pkg::PORT_W_DIR)) u_arb_w (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_port_i  (req_port),
    .credit_i    (out_credit_i[noc_router_pkg::PORT_W_DIR]),
    .grant_o     (arb_grant[noc_router_pkg::PORT_W_DIR*noc_router_pkg::NUM_PORTS
                            +: noc_router_pkg::NUM_PORTS])
  );

  port_arbiter #(.OUT_PORT(noc_router_pkg::PORT_E)) u_arb_e (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_port_i  (req_port),
    .credit_i    (out_credit_i[noc_router_pkg::PORT_E]),
    .grant_o     (arb_grant[noc_router_pkg::PORT_E*noc_router_pkg::NUM_PORTS
                            +: noc_router_pkg::NUM_PORTS])
  );

  port_arbiter #(.OUT_PORT(noc_router_pkg::PORT_L)) u_arb_l (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_port_i  (req_port),
    .credit_i    (out_credit_i[noc_router_pkg::PORT_L]),
    .grant_o     (arb_grant[noc_router_pkg::PORT_L*noc_router_pkg::NUM_PORTS
                            +: noc_router_pkg::NUM_PORTS])
  );

  switch_traversal u_switch (
    .clk         (clk),
    .rst_i       (rst_i),
    .arb_grant_i (arb_grant),
    .held_flit_i (held_flit),
    .in_grant_o  (in_grant),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o),
    .in_credit_o (in_credit_o)
  );

endmodule

`default_nettype wire

//--- source/noc_router_pkg.sv
//*********************************************************************
// Shared constants for the mesh router: flit field layout, port codes
// and downstream buffer depth. Files refer to these by scoped name.
//*********************************************************************

`default_nettype none

package noc_router_pkg;

  // dst x in 15:13, dst y in 12:10 and payload in 9:0
  localparam int FLIT_W    = 16;
  localparam int COORD_W   = 3;
  localparam int DST_X_LSB = 13;
  localparam int DST_Y_LSB = 10;

  localparam int NUM_PORTS = 5;
  localparam int PORT_W    = 3;

  // port code doubles as bit or slice index in every port vector
  localparam logic [PORT_W-1:0] PORT_N     = 3'd0;
  localparam logic [PORT_W-1:0] PORT_S     = 3'd1;
  localparam logic [PORT_W-1:0] PORT_W_DIR = 3'd2;
  localparam logic [PORT_W-1:0] PORT_E     = 3'd3;
  localparam logic [PORT_W-1:0] PORT_L     = 3'd4;

  // slots in the next router's input buffer, also the credit reset value
  localparam int BUF_DEPTH = 4;
  localparam int CREDIT_W  = 3;

endpackage

`default_nettype wire

//--- source/port_arbiter.sv
//*********************************************************************
// Round-robin arbiter for one output port. Picks one of the inputs
// whose request targets OUT_PORT, starting one past the last winner,
// and only while the downstream buffer has a free slot. One instance
// per output port.
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

module port_arbiter #(
  parameter logic [noc_router_pkg::PORT_W-1:0] OUT_PORT = noc_router_pkg::PORT_L
) (
  input  wire                                                         clk,
  input  wire                                                         rst_i,
  input  wire  [noc_router_pkg::NUM_PORTS-1:0]                        req_valid_i,
  input  wire  [noc_router_pkg::NUM_PORTS*noc_router_pkg::PORT_W-1:0] req_port_i,
  input  wire                                                         credit_i,
  output logic [noc_router_pkg::NUM_PORTS-1:0]                        grant_o
);

  logic [noc_router_pkg::NUM_PORTS-1:0] req_match;
  logic [noc_router_pkg::PORT_W-1:0]    ptr_q;
  logic [noc_router_pkg::PORT_W-1:0]    winner;
  logic [noc_router_pkg::CREDIT_W-1:0]  credit_q;
  logic                                 have_credit;
  logic                                 granted;

  // inputs asking for this output
  always_comb begin
    for (int i = 0; i < noc_router_pkg::NUM_PORTS; i++) begin
      req_match[i] = req_valid_i[i] &&
        (req_port_i[i*noc_router_pkg::PORT_W +: noc_router_pkg::PORT_W] == OUT_PORT);
    end
  end

  assign have_credit = (credit_q != '0);

  // scan from ptr_q + 1 around to ptr_q itself
  always_comb begin : pick
    int   idx;
    logic found;
    grant_o = '0;
    winner  = ptr_q;
    found   = 1'b0;
    for (int off = 1; off <= noc_router_pkg::NUM_PORTS; off++) begin
      idx = int'(ptr_q) + off;
      if (idx >= noc_router_pkg::NUM_PORTS) begin
        idx = idx - noc_router_pkg::NUM_PORTS;
      end
      if (!found && have_credit && req_match[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        winner       = idx[noc_router_pkg::PORT_W-1:0];
      end
    end
  end

  assign granted = |grant_o;

  // starts at L so that N is first in line after reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ptr_q <= noc_router_pkg::PORT_L;
    end else if (granted) begin
      ptr_q <= winner;
    end
  end

  // one slot used per grant, one back per downstream credit pulse
  always_ff @(posedge clk) begin
    if (rst_i) begin
      credit_q <= noc_router_pkg::BUF_DEPTH[noc_router_pkg::CREDIT_W-1:0];
    end else begin
      case ({granted, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(grant_o));

  // nothing is sent into a full downstream buffer
  a_no_grant_empty: assert property (@(posedge clk) disable iff (rst_i)
    granted |-> (credit_q != '0));

  // downstream must not return more credits than flits it received
  a_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
    credit_q <= noc_router_pkg::BUF_DEPTH);

endmodule

`default_nettype wire

//--- source/route_compute.sv
//*********************************************************************
// Input stage of the router. Holds one flit per input port and works
// out its output port by XY dimension-order routing. The request stays
// up until the switch grants it.
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

module route_compute #(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  wire                                clk,
  input  wire                                rst_i,
  input  wire                                flit_valid_i,
  input  wire  [noc_router_pkg::FLIT_W-1:0]  flit_i,
  input  wire                                grant_i,
  output logic                               req_valid_o,
  output logic [noc_router_pkg::PORT_W-1:0]  req_port_o,
  output logic [noc_router_pkg::FLIT_W-1:0]  flit_o
);

  logic [noc_router_pkg::COORD_W-1:0] dst_x;
  logic [noc_router_pkg::COORD_W-1:0] dst_y;
  logic [noc_router_pkg::PORT_W-1:0]  next_port;
  logic                               take_flit;

  assign dst_x = flit_i[noc_router_pkg::DST_X_LSB +: noc_router_pkg::COORD_W];
  assign dst_y = flit_i[noc_router_pkg::DST_Y_LSB +: noc_router_pkg::COORD_W];

  // resolve x first, y only once the column matches
  always_comb begin
    if (int'(dst_x) > X_POS) begin
      next_port = noc_router_pkg::PORT_E;
    end else if (int'(dst_x) < X_POS) begin
      next_port = noc_router_pkg::PORT_W_DIR;
    end else if (int'(dst_y) > Y_POS) begin
      next_port = noc_router_pkg::PORT_N;
    end else if (int'(dst_y) < Y_POS) begin
      next_port = noc_router_pkg::PORT_S;
    end else begin
      next_port = noc_router_pkg::PORT_L;
    end
  end

  // slot is free when empty or when its flit leaves this cycle
  assign take_flit = flit_valid_i && (!req_valid_o || grant_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      req_valid_o <= 1'b0;
    end else if (take_flit) begin
      req_valid_o <= 1'b1;
    end else if (grant_i) begin
      req_valid_o <= 1'b0;
    end
  end

  // flit and its route code
  always_ff @(posedge clk) begin
    if (take_flit) begin
      flit_o     <= flit_i;
      req_port_o <= next_port;
    end
  end

  // sender holds one credit, so a full slot only refills as it drains
  a_no_overrun: assert property (@(posedge clk) disable iff (rst_i)
    (flit_valid_i && req_valid_o) |-> grant_i);

  // the arbiters never grant an input with nothing held
  a_grant_has_req: assert property (@(posedge clk) disable iff (rst_i)
    grant_i |-> req_valid_o);

endmodule

`default_nettype wire

//--- source/switch_traversal.sv
//*********************************************************************
// Crossbar stage. Folds the per-output grants back onto the inputs,
// selects each output's winning flit and registers it onto the router
// outputs together with the upstream credit pulse.
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

module switch_traversal (
  input  wire                                                         clk,
  input  wire                                                         rst_i,
  input  wire  [noc_router_pkg::NUM_PORTS*noc_router_pkg::NUM_PORTS-1:0] arb_grant_i,
  input  wire  [noc_router_pkg::NUM_PORTS*noc_router_pkg::FLIT_W-1:0] held_flit_i,
  output logic [noc_router_pkg::NUM_PORTS-1:0]                        in_grant_o,
  output logic [noc_router_pkg::NUM_PORTS-1:0]                        out_valid_o,
  output logic [noc_router_pkg::NUM_PORTS*noc_router_pkg::FLIT_W-1:0] out_flit_o,
  output logic [noc_router_pkg::NUM_PORTS-1:0]                        in_credit_o
);

  logic [noc_router_pkg::NUM_PORTS*noc_router_pkg::FLIT_W-1:0] sel_flit;
  logic [noc_router_pkg::NUM_PORTS-1:0]                        out_hit;

  // slice o of arb_grant_i belongs to output o, bit i to input i
  always_comb begin
    in_grant_o = '0;
    for (int o = 0; o < noc_router_pkg::NUM_PORTS; o++) begin
      out_hit[o] = |arb_grant_i[o*noc_router_pkg::NUM_PORTS +: noc_router_pkg::NUM_PORTS];
      for (int i = 0; i < noc_router_pkg::NUM_PORTS; i++) begin
        in_grant_o[i] = in_grant_o[i] | arb_grant_i[o*noc_router_pkg::NUM_PORTS + i];
      end
    end
  end

  // grant slices are one-hot, so an and-or mux will do
  always_comb begin
    sel_flit = '0;
    for (int o = 0; o < noc_router_pkg::NUM_PORTS; o++) begin
      for (int i = 0; i < noc_router_pkg::NUM_PORTS; i++) begin
        if (arb_grant_i[o*noc_router_pkg::NUM_PORTS + i]) begin
          sel_flit[o*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W] =
            sel_flit[o*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W] |
            held_flit_i[i*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_o <= '0;
      in_credit_o <= '0;
    end else begin
      out_valid_o <= out_hit;
      in_credit_o <= in_grant_o;
    end
  end

  // output data only moves when that port wins
  always_ff @(posedge clk) begin
    for (int o = 0; o < noc_router_pkg::NUM_PORTS; o++) begin
      if (out_hit[o]) begin
        out_flit_o[o*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W] <=
          sel_flit[o*noc_router_pkg::FLIT_W +: noc_router_pkg::FLIT_W];
      end
    end
  end

  // one route per input, so no two arbiters grant the same input
  a_single_grant: assert property (@(posedge clk) disable iff (rst_i)
    $countones(arb_grant_i) == $countones(in_grant_o));

endmodule

`default_nettype wire

//--- verification/noc_router_tb.sv
//*********************************************************************
// Testbench for the mesh router switch core at (3, 4). Drives random
// one-flit traffic and models the downstream buffers. A cycle-accurate
// model predicts every output. Run with the file list as the only input.
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

module noc_router_tb;

  localparam int NP = noc_router_pkg::NUM_PORTS;
  localparam int FW = noc_router_pkg::FLIT_W;
  localparam int DEPTH = noc_router_pkg::BUF_DEPTH;
  localparam int ROUTER_X = 3;
  localparam int ROUTER_Y = 4;
  localparam int P_N = int'(noc_router_pkg::PORT_N);
  localparam int P_S = int'(noc_router_pkg::PORT_S);
  localparam int P_W = int'(noc_router_pkg::PORT_W_DIR);
  localparam int P_E = int'(noc_router_pkg::PORT_E);
  localparam int P_L = int'(noc_router_pkg::PORT_L);
  // worst case cycles per test, waits and drains included
  localparam int WATCHDOG_CYC = 10 + 20 * 231 + 502 + 300 + 600 + 100;

  logic clk, rst_i;
  logic [NP-1:0] in_valid_i, out_credit_i, drv_valid;
  logic [NP*FW-1:0] in_flit_i;
  wire [NP-1:0] in_credit_o, out_valid_o;
  wire [NP*FW-1:0] out_flit_o;

  // router model state
  logic m_valid [NP];
  int m_port [NP], m_ptr [NP], m_cnt [NP];
  logic [FW-1:0] m_flit [NP], e_flit [NP], send_flit [NP], obs_flit [NP];
  logic [NP-1:0] e_valid, e_credit, obs_valid, obs_credit;
  logic snd_credit [NP], send_req [NP], withhold [NP];
  int strobe_cyc [NP], sent_cnt [NP], credit_cnt [NP];
  int ret_q [NP][$];
  int live [int];
  int rx_cnt, delay_max, cyc, err_cnt, test_err0;
  bit model_ready;
  logic [31:0] seed;
  logic [6:0] seq;

  noc_router #(.X_POS(ROUTER_X), .Y_POS(ROUTER_Y)) u_dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_flit_i    (in_flit_i),
    .out_credit_i (out_credit_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  function automatic int unsigned rand_below(input int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 8) % n;
  endfunction

  // x first, then y
  function automatic int xy_port(input logic [FW-1:0] fl);
    int dx;
    int dy;
    int port;
    dx = int'(fl[noc_router_pkg::DST_X_LSB +: noc_router_pkg::COORD_W]);
    dy = int'(fl[noc_router_pkg::DST_Y_LSB +: noc_router_pkg::COORD_W]);
    port = P_L;
    if (dx > ROUTER_X) port = P_E;
    else if (dx < ROUTER_X) port = P_W;
    else if (dy > ROUTER_Y) port = P_N;
    else if (dy < ROUTER_Y) port = P_S;
    return port;
  endfunction

  // payload carries source in 9:7 and a sequence number
  task automatic queue_send(input int src, input int dx, input int dy);
    send_flit[src] = '0;
    send_flit[src][noc_router_pkg::DST_X_LSB +: noc_router_pkg::COORD_W] = dx[2:0];
    send_flit[src][noc_router_pkg::DST_Y_LSB +: noc_router_pkg::COORD_W] = dy[2:0];
    send_flit[src][9:0] = {src[2:0], seq};
    seq = seq + 1'b1;
    send_req[src] = 1'b1;
  endtask

  task automatic reset_model();
    for (int i = 0; i < NP; i++) begin
      m_valid[i] = 1'b0;
      m_ptr[i] = P_L;
      m_cnt[i] = DEPTH;
      snd_credit[i] = 1'b1;
      send_req[i] = 1'b0;
      ret_q[i].delete();
    end
    e_valid = '0;
    e_credit = '0;
    model_ready = 1'b1;
  endtask

  task automatic check_outputs();
    if (out_valid_o !== e_valid) begin
      $display("FAILED out_valid_o expected %h got %h", e_valid, out_valid_o);
      err_cnt++;
    end
    if (in_credit_o !== e_credit) begin
      $display("FAILED in_credit_o expected %h got %h", e_credit, in_credit_o);
      err_cnt++;
    end
    for (int o = 0; o < NP; o++) begin
      if (e_valid[o] && out_flit_o[o*FW +: FW] !== e_flit[o]) begin
        $display("FAILED out_flit_o[%0d] expected %h got %h", o, e_flit[o],
                 out_flit_o[o*FW +: FW]);
        err_cnt++;
      end
    end
  endtask

  // bookkeeping on the values seen just before the edge
  task automatic track_traffic();
    int key;
    obs_valid = out_valid_o;
    obs_credit = in_credit_o;
    for (int o = 0; o < NP; o++) begin
      obs_flit[o] = out_flit_o[o*FW +: FW];
      if (out_valid_o[o] === 1'b1) begin
        key = int'(obs_flit[o]);
        if (live.exists(key)) begin
          live[key] = live[key] - 1;
          if (live[key] == 0) live.delete(key);
        end else begin
          $display("flit %h left output %0d but was never sent or left twice", key, o);
          err_cnt++;
        end
        rx_cnt++;
        ret_q[o].push_back(cyc + 1 + int'(rand_below(delay_max)));
      end
      if (in_credit_o[o] === 1'b1) begin
        snd_credit[o] = 1'b1;
        credit_cnt[o]++;
      end
      if (in_valid_i[o] === 1'b1) strobe_cyc[o] = cyc;
    end
  endtask

  task automatic model_step();
    int win [NP];
    int idx;
    logic [NP-1:0] in_grant;
    in_grant = '0;
    for (int o = 0; o < NP; o++) begin
      win[o] = -1;
      for (int off = 1; off <= NP; off++) begin
        idx = (m_ptr[o] + off) % NP;
        if (win[o] < 0 && m_cnt[o] > 0 && m_valid[idx] && m_port[idx] == o) win[o] = idx;
      end
      e_valid[o] = (win[o] >= 0);
      if (win[o] >= 0) begin
        e_flit[o] = m_flit[win[o]];
        in_grant[win[o]] = 1'b1;
        m_ptr[o] = win[o];
        m_cnt[o] = m_cnt[o] - 1;
      end
      if (out_credit_i[o]) m_cnt[o] = m_cnt[o] + 1;
    end
    e_credit = in_grant;
    for (int i = 0; i < NP; i++) begin
      if (in_valid_i[i] && (!m_valid[i] || in_grant[i])) begin
        m_valid[i] = 1'b1;
        m_flit[i] = in_flit_i[i*FW +: FW];
        m_port[i] = xy_port(m_flit[i]);
      end else if (in_grant[i]) begin
        m_valid[i] = 1'b0;
      end
    end
  endtask

  task automatic drive_inputs();
    logic [NP*FW-1:0] f;
    logic [NP-1:0] c;
    drv_valid = '0;
    f = in_flit_i;
    c = '0;
    for (int i = 0; i < NP; i++) begin
      if (send_req[i] && !snd_credit[i]) begin
        $display("input %0d tried to send without holding a credit", i);
        err_cnt++;
      end else if (send_req[i]) begin
        drv_valid[i] = 1'b1;
        f[i*FW +: FW] = send_flit[i];
        snd_credit[i] = 1'b0;
        sent_cnt[i]++;
        live[int'(send_flit[i])] = live.exists(int'(send_flit[i])) ?
                                   live[int'(send_flit[i])] + 1 : 1;
      end
      send_req[i] = 1'b0;
      if (!withhold[i] && ret_q[i].size() > 0 && ret_q[i][0] <= cyc) begin
        c[i] = 1'b1;
        void'(ret_q[i].pop_front());
      end
    end
    in_valid_i <= drv_valid;
    in_flit_i <= f;
    out_credit_i <= c;
  endtask

  task automatic step();
    @(posedge clk);
    cyc++;
    if (model_ready) begin
      check_outputs();
      track_traffic();
    end
    if (rst_i) reset_model();
    else model_step();
    drive_inputs();
  endtask

  task automatic drain();
    int waited;
    bit busy;
    waited = 0;
    busy = 1'b1;
    while (busy && waited < 200) begin
      step();
      waited++;
      busy = (drv_valid != '0) || (e_valid != '0) || (e_credit != '0);
      for (int i = 0; i < NP; i++) begin
        if (m_valid[i] || ret_q[i].size() != 0 || m_cnt[i] != DEPTH) busy = 1'b1;
      end
    end
    if (busy) begin
      $display("router did not drain within 200 cycles");
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  task automatic send_single_flits();
    int src, port, waited;
    logic [NP-1:0] exp_vec;
    delay_max = 4;
    for (int n = 0; n < 20; n++) begin
      src = rand_below(NP);
      queue_send(src, rand_below(8), rand_below(8));
      port = xy_port(send_flit[src]);
      exp_vec = '0;
      exp_vec[port] = 1'b1;
      waited = 0;
      step();
      while (obs_valid == '0 && waited < 30) begin
        step();
        waited++;
      end
      if (waited >= 30) begin
        $display("flit %h from input %0d never left the router", send_flit[src], src);
        err_cnt++;
      end else begin
        if (obs_valid !== exp_vec) begin
          $display("FAILED out_valid_o expected %h got %h", exp_vec, obs_valid);
          err_cnt++;
        end
        if (obs_flit[port] !== send_flit[src]) begin
          $display("FAILED out_flit_o[%0d] expected %h got %h", port, send_flit[src],
                   obs_flit[port]);
          err_cnt++;
        end
        if (cyc - strobe_cyc[src] != 2) begin
          $display("flit took %0d cycles instead of 2 to cross", cyc - strobe_cyc[src]);
          err_cnt++;
        end
      end
      drain();
    end
  endtask

  // all five inputs keep sending to east, winners must cycle N S W E L
  task automatic contend_for_east();
    int wins, src, waited;
    delay_max = 6;
    rst_i <= 1'b1;
    repeat (2) step();
    rst_i <= 1'b0;
    wins = 0;
    waited = 0;
    while (wins < 25 && waited < 300) begin
      for (int i = 0; i < NP; i++) begin
        if (snd_credit[i] && !send_req[i]) queue_send(i, 4 + rand_below(4), rand_below(8));
      end
      step();
      waited++;
      if (obs_valid[P_E]) begin
        src = obs_flit[P_E][9:7];
        if (src != wins % NP) begin
          $display("east grant %0d went to input %0d, out of round-robin order", wins, src);
          err_cnt++;
        end
        wins++;
      end
    end
    if (wins < 25) begin
      $display("only %0d flits left the east port in 300 cycles", wins);
      err_cnt++;
    end
    drain();
  endtask

  // west credits withheld while east and local keep flowing
  task automatic stall_west_output();
    int w_out, other_out, prev, src, drained;
    delay_max = 3;
    w_out = 0;
    other_out = 0;
    prev = 0;
    drained = 0;
    withhold[P_W] = 1'b1;
    repeat (60) begin
      for (int i = 0; i < 3; i++) begin
        if (snd_credit[i] && !send_req[i]) queue_send(i, rand_below(3), rand_below(8));
      end
      if (snd_credit[3] && !send_req[3]) queue_send(3, ROUTER_X, ROUTER_Y);
      if (snd_credit[4] && !send_req[4]) queue_send(4, 4 + rand_below(4), rand_below(8));
      step();
      if (obs_valid[P_W]) begin
        w_out++;
        prev = obs_flit[P_W][9:7];
      end
      // only counts once west has used up its credits
      if ((obs_valid[P_E] || obs_valid[P_L]) && w_out >= DEPTH) other_out++;
    end
    if (w_out != DEPTH) begin
      $display("FAILED out_valid_o[%0d] pulses expected %h got %h", P_W, DEPTH, w_out);
      err_cnt++;
    end
    if (other_out == 0) begin
      $display("east and local outputs stopped while west was stalled");
      err_cnt++;
    end
    withhold[P_W] = 1'b0;
    repeat (40) begin
      step();
      if (obs_valid[P_W]) begin
        src = obs_flit[P_W][9:7];
        if (src != (prev + 1) % 3) begin
          $display("west drained input %0d after input %0d, out of order", src, prev);
          err_cnt++;
        end
        prev = src;
        drained++;
      end
    end
    if (drained != 3) begin
      $display("FAILED out_valid_o[%0d] pulses expected %h got %h", P_W, 3, drained);
      err_cnt++;
    end
    drain();
  endtask

  task automatic random_traffic();
    int total;
    delay_max = 8;
    rx_cnt = 0;
    total = 0;
    for (int i = 0; i < NP; i++) begin
      sent_cnt[i] = 0;
      credit_cnt[i] = 0;
    end
    repeat (400) begin
      for (int i = 0; i < NP; i++) begin
        if (snd_credit[i] && !send_req[i] && rand_below(4) != 0) begin
          queue_send(i, rand_below(8), rand_below(8));
        end
      end
      step();
    end
    drain();
    for (int i = 0; i < NP; i++) begin
      total += sent_cnt[i];
      if (credit_cnt[i] != sent_cnt[i]) begin
        $display("FAILED in_credit_o[%0d] pulses expected %h got %h", i, sent_cnt[i],
                 credit_cnt[i]);
        err_cnt++;
      end
    end
    if (rx_cnt != total) begin
      $display("FAILED out_valid_o pulses expected %h got %h", total, rx_cnt);
      err_cnt++;
    end
    if (live.size() != 0) begin
      $display("%0d sent flits never left the router", live.size());
      err_cnt++;
    end
  endtask

  initial begin
    rst_i = 1'b1;
    in_valid_i = '0;
    in_flit_i = '0;
    out_credit_i = '0;
    drv_valid = '0;
    seed = 32'h4d63_2fbf;
    seq = '0;
    cyc = 0;
    err_cnt = 0;
    test_err0 = 0;
    rx_cnt = 0;
    delay_max = 1;
    model_ready = 1'b0;
    for (int i = 0; i < NP; i++) begin
      withhold[i] = 1'b0;
      send_req[i] = 1'b0;
      snd_credit[i] = 1'b1;
      sent_cnt[i] = 0;
      credit_cnt[i] = 0;
      strobe_cyc[i] = 0;
    end
    // 8 reset edges, then one more look after release
    for (int n = 0; n < 10; n++) begin
      if (n == 8) rst_i <= 1'b0;
      step();
      if (n > 0 && obs_valid !== '0) begin
        $display("FAILED out_valid_o expected %h got %h", 5'h00, obs_valid);
        err_cnt++;
      end
      if (n > 0 && obs_credit !== '0) begin
        $display("FAILED in_credit_o expected %h got %h", 5'h00, obs_credit);
        err_cnt++;
      end
    end
    report_test("reset");
    send_single_flits();
    report_test("routing");
    contend_for_east();
    report_test("round_robin");
    stall_west_output();
    report_test("credit_stall");
    random_traffic();
    report_test("random_traffic");
    $display("5 tests run, %0d checks failed", err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * 20);
    $display("watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
